/* build.f */
+incdir+rtl
rtl/mem_pkg.sv
rtl/free_list_if.sv
rtl/init_sequencer.sv
rtl/free_list_bank.sv
rtl/bank_allocator.sv
rtl/bank_array.sv
rtl/banked_freelist_mem.sv
verif/tb_banked_freelist_mem.sv

/* rtl/bank_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module bank_allocator (
  input  logic           clk,
  input  logic           rst,
  input  logic           ready,
  input  logic           vwrite,
  input  logic           vdeq,
  input  mem_pkg::data_t vdin,
  input  mem_pkg::addr_t vdqaddr,
  input  mem_pkg::thr_t  bp_thr,
  free_list_if.alloc     fl [`MEM_NUM_BANKS],
  output mem_pkg::addr_t vwraddr,
  output logic           wr_en,
  output mem_pkg::addr_t wr_addr,
  output mem_pkg::data_t wr_data,
  output logic           vwrite_bp
);

  mem_pkg::cnt_t             cnt [`MEM_NUM_BANKS];
  mem_pkg::row_t             head [`MEM_NUM_BANKS];
  logic [`MEM_NUM_BANKS-1:0] pop_vec;
  logic [`MEM_NUM_BANKS-1:0] push_vec;
  logic                      any_free;
  mem_pkg::bank_t            sel_bank;
  logic                      wr_go;
  logic                      dq_go;
  mem_pkg::bank_t            dq_bank;
  mem_pkg::row_t             dq_row;
  mem_pkg::total_t           total;

  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
    assign cnt[b]         = fl[b].count;
    assign head[b]        = fl[b].head_row;
    assign fl[b].pop      = pop_vec[b];
    assign fl[b].push     = push_vec[b];
    assign fl[b].push_row = dq_row;
  end

  // lowest bank with a free row wins
  always_comb begin
    any_free = 1'b0;
    sel_bank = '0;
    for (int i = `MEM_NUM_BANKS - 1; i >= 0; i--) begin
      if (cnt[i] != '0) begin
        any_free = 1'b1;
        sel_bank = mem_pkg::bank_t'(i);
      end
    end
  end

  assign wr_go   = vwrite && ready && any_free;
  assign vwraddr = {sel_bank, head[sel_bank]};
  assign wr_en   = wr_go;
  assign wr_addr = vwraddr;
  assign wr_data = vdin;

  // returned row goes to the tail of its own bank
  assign dq_go   = vdeq && ready;
  assign dq_bank = vdqaddr[`MEM_ROW_BITS +: `MEM_BANK_BITS];
  assign dq_row  = vdqaddr[`MEM_ROW_BITS-1:0];

  always_comb begin
    pop_vec  = '0;
    push_vec = '0;
    if (wr_go) begin
      pop_vec[sel_bank] = 1'b1;
    end
    if (dq_go) begin
      push_vec[dq_bank] = 1'b1;
    end
  end

  always_comb begin
    total = '0;
    for (int i = 0; i < `MEM_NUM_BANKS; i++) begin
      total = total + mem_pkg::total_t'(cnt[i]);
    end
  end

  // back-pressure level lags the counts by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      vwrite_bp <= 1'b1;
    end else begin
      vwrite_bp <= ({1'b0, total} <= bp_thr);
    end
  end

  a_write_has_row: assert property (@(posedge clk) disable iff (rst)
    (vwrite && ready) |-> any_free)
    else $error("write dropped, no free row in any bank");

endmodule

`default_nettype wire

/* rtl/bank_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module bank_array (
  input  logic           clk,
  input  logic           rst,
  input  logic           ready,
  input  logic           wr_en,
  input  logic           vread,
  input  mem_pkg::addr_t wr_addr,
  input  mem_pkg::addr_t vrdaddr,
  input  mem_pkg::data_t wr_data,
  output logic           vread_vld,
  output mem_pkg::data_t vdout
);

  mem_pkg::bank_t            wr_bank;
  mem_pkg::row_t             wr_row;
  logic                      rd_go;
  logic [`MEM_READ_DELAY-1:0] vld_pipe;
  mem_pkg::bank_t            bank_pipe [`MEM_READ_DELAY];
  mem_pkg::row_t             row_pipe [`MEM_READ_DELAY];
  mem_pkg::data_t            rd_word [`MEM_NUM_BANKS];

  assign wr_bank = wr_addr[`MEM_ROW_BITS +: `MEM_BANK_BITS];
  assign wr_row  = wr_addr[`MEM_ROW_BITS-1:0];
  assign rd_go   = vread && ready;

  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
    mem_pkg::data_t mem [`MEM_NUM_ROWS];

    always_ff @(posedge clk) begin
      if (wr_en && (wr_bank == mem_pkg::bank_t'(b))) begin
        mem[wr_row] <= wr_data;
      end
    end

    // every bank looks up the row leaving the pipe
    assign rd_word[b] = mem[row_pipe[`MEM_READ_DELAY-1]];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= rd_go;
      for (int i = 1; i < `MEM_READ_DELAY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bank_pipe[0] <= vrdaddr[`MEM_ROW_BITS +: `MEM_BANK_BITS];
    row_pipe[0]  <= vrdaddr[`MEM_ROW_BITS-1:0];
    for (int i = 1; i < `MEM_READ_DELAY; i++) begin
      bank_pipe[i] <= bank_pipe[i-1];
      row_pipe[i]  <= row_pipe[i-1];
    end
  end

  assign vread_vld = vld_pipe[`MEM_READ_DELAY-1];
  assign vdout     = rd_word[bank_pipe[`MEM_READ_DELAY-1]];

endmodule

`default_nettype wire

/* rtl/banked_freelist_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module banked_freelist_mem (
  input  logic           clk,
  input  logic           rst,
  input  logic           vwrite,
  input  mem_pkg::data_t vdin,
  input  logic           vread,
  input  mem_pkg::addr_t vrdaddr,
  input  logic           vdeq,
  input  mem_pkg::addr_t vdqaddr,
  input  mem_pkg::thr_t  bp_thr,
  output logic           ready,
  output logic           vwrite_bp,
  output mem_pkg::addr_t vwraddr,
  output logic           vread_vld,
  output mem_pkg::data_t vdout
);

  logic           init_push;
  mem_pkg::row_t  init_row;
  logic           wr_en;
  mem_pkg::addr_t wr_addr;
  mem_pkg::data_t wr_data;

  free_list_if fl_if [`MEM_NUM_BANKS] ();

  init_sequencer init_sequencer_inst (
    .clk       (clk),
    .rst       (rst),
    .init_push (init_push),
    .init_row  (init_row),
    .ready     (ready)
  );

  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_list
    free_list_bank free_list_bank_inst (
      .clk       (clk),
      .rst       (rst),
      .init_push (init_push),
      .init_row  (init_row),
      .fl        (fl_if[b])
    );
  end

  bank_allocator bank_allocator_inst (
    .clk       (clk),
    .rst       (rst),
    .ready     (ready),
    .vwrite    (vwrite),
    .vdeq      (vdeq),
    .vdin      (vdin),
    .vdqaddr   (vdqaddr),
    .bp_thr    (bp_thr),
    .fl        (fl_if),
    .vwraddr   (vwraddr),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .vwrite_bp (vwrite_bp)
  );

  bank_array bank_array_inst (
    .clk       (clk),
    .rst       (rst),
    .ready     (ready),
    .wr_en     (wr_en),
    .vread     (vread),
    .wr_addr   (wr_addr),
    .vrdaddr   (vrdaddr),
    .wr_data   (wr_data),
    .vread_vld (vread_vld),
    .vdout     (vdout)
  );

endmodule

`default_nettype wire

/* rtl/free_list_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module free_list_bank (
  input  logic          clk,
  input  logic          rst,
  input  logic          init_push,
  input  mem_pkg::row_t init_row,
  free_list_if.list     fl
);

  mem_pkg::row_t rows [`MEM_NUM_ROWS];
  mem_pkg::row_t head_ptr;
  mem_pkg::row_t tail_ptr;
  mem_pkg::cnt_t count_q;
  logic          push_any;
  mem_pkg::row_t push_val;

  // sweep and dequeue share the tail, they never overlap
  assign push_any = init_push | fl.push;
  assign push_val = init_push ? init_row : fl.push_row;

  always_ff @(posedge clk) begin
    if (push_any) begin
      rows[tail_ptr] <= push_val;
    end
  end

  // pointers wrap on their own width, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count_q  <= '0;
    end else begin
      if (fl.pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      if (push_any) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      case ({push_any, fl.pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign fl.head_row = rows[head_ptr];
  assign fl.count    = count_q;

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    fl.pop |-> (count_q != '0));

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push_any |-> (count_q != mem_pkg::cnt_t'(`MEM_NUM_ROWS)));

  // allocator holds dequeues back until the sweep has finished
  a_no_push_clash: assert property (@(posedge clk) disable iff (rst)
    !(init_push && fl.push));

endmodule

`default_nettype wire

/* rtl/free_list_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

interface free_list_if;

  // allocator side
  logic                     pop;
  logic                     push;
  logic [`MEM_ROW_BITS-1:0] push_row;

  // list side
  logic [`MEM_ROW_BITS-1:0] head_row;
  logic [`MEM_CNT_BITS-1:0] count;

  modport alloc (
    output pop,
    output push,
    output push_row,
    input  head_row,
    input  count
  );

  modport list (
    input  pop,
    input  push,
    input  push_row,
    output head_row,
    output count
  );

endinterface

`default_nettype wire

/* rtl/init_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module init_sequencer (
  input  logic          clk,
  input  logic          rst,
  output logic          init_push,
  output mem_pkg::row_t init_row,
  output logic          ready
);

  mem_pkg::init_state_e state;
  mem_pkg::row_t        row_q;

  // one row per cycle into every bank, ascending
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_pkg::SWEEP;
      row_q <= '0;
    end else if (state == mem_pkg::SWEEP) begin
      row_q <= row_q + 1'b1;
      if (row_q == mem_pkg::row_t'(`MEM_NUM_ROWS - 1)) begin
        state <= mem_pkg::DONE;
      end
    end
  end

  assign init_push = (state == mem_pkg::SWEEP);
  assign init_row  = row_q;
  assign ready     = (state == mem_pkg::DONE);

  // ready rises exactly one full sweep after reset is released
  a_sweep_length: assert property (@(posedge clk) disable iff (rst)
    $rose(ready) |-> ($past(rst, `MEM_NUM_ROWS + 1) && !$past(rst, `MEM_NUM_ROWS)));

endmodule

`default_nettype wire

/* rtl/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// storage geometry
`define MEM_WIDTH       16
`define MEM_NUM_BANKS   4
`define MEM_BANK_BITS   2
`define MEM_NUM_ROWS    16
`define MEM_ROW_BITS    4

// one extra bit so a count can hold a full bank or a full store
`define MEM_CNT_BITS    5
`define MEM_TOTAL_BITS  7

`define MEM_READ_DELAY  2

`endif

/* rtl/mem_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

  typedef logic [`MEM_WIDTH-1:0] data_t;
  typedef logic [`MEM_BANK_BITS-1:0] bank_t;
  typedef logic [`MEM_ROW_BITS-1:0] row_t;

  // bank in the upper bits, row in the lower bits
  typedef logic [`MEM_BANK_BITS+`MEM_ROW_BITS-1:0] addr_t;

  typedef logic [`MEM_CNT_BITS-1:0] cnt_t;
  typedef logic [`MEM_TOTAL_BITS-1:0] total_t;
  typedef logic [7:0] thr_t;

  typedef enum logic {
    SWEEP,
    DONE
  } init_state_e;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_banked_freelist_mem -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

/* verif/tb_banked_freelist_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tb_banked_freelist_mem;

  localparam int OP_IDLE     = 0;
  localparam int OP_WRITE    = 1;
  localparam int OP_READ     = 2;
  localparam int OP_DEQ      = 3;
  localparam int OP_THR      = 4;
  localparam int MAX_ENTRIES = 128;
  localparam int NUM_TESTS   = 4;

  logic           clk;
  logic           rst;
  logic           vwrite;
  mem_pkg::data_t vdin;
  logic           vread;
  mem_pkg::addr_t vrdaddr;
  logic           vdeq;
  mem_pkg::addr_t vdqaddr;
  mem_pkg::thr_t  bp_thr;
  logic           ready;
  logic           vwrite_bp;
  mem_pkg::addr_t vwraddr;
  logic           vread_vld;
  mem_pkg::data_t vdout;

  // t_exp holds a hand-derived write address or -1
  int             t_op   [MAX_ENTRIES];
  int             t_test [MAX_ENTRIES];
  mem_pkg::addr_t t_addr [MAX_ENTRIES];
  mem_pkg::data_t t_data [MAX_ENTRIES];
  int             t_exp  [MAX_ENTRIES];
  int             n_entries;

  // reference model
  mem_pkg::row_t  free_q [`MEM_NUM_BANKS][$];
  mem_pkg::data_t shadow [2**(`MEM_BANK_BITS+`MEM_ROW_BITS)];
  logic           m_vld  [2];
  mem_pkg::data_t m_data [2];
  logic           m_bp;

  int    cycles = 0;
  int    timeout_limit = 0;
  int    errors;
  int    test_errors;
  int    tests_run;
  int    tests_failed;
  string test_name [NUM_TESTS];

  banked_freelist_mem banked_freelist_mem_inst (
    .clk       (clk),
    .rst       (rst),
    .vwrite    (vwrite),
    .vdin      (vdin),
    .vread     (vread),
    .vrdaddr   (vrdaddr),
    .vdeq      (vdeq),
    .vdqaddr   (vdqaddr),
    .bp_thr    (bp_thr),
    .ready     (ready),
    .vwrite_bp (vwrite_bp),
    .vwraddr   (vwraddr),
    .vread_vld (vread_vld),
    .vdout     (vdout)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (timeout_limit > 0 && cycles >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [15:0] exp_val,
                                 input logic [15:0] got_val);
    $display("Mismatch at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp_val, got_val);
    errors++;
    test_errors++;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic add_entry(input int test, input int op, input int addr, input int data,
                           input int exp);
    t_test[n_entries] = test;
    t_op[n_entries]   = op;
    t_addr[n_entries] = mem_pkg::addr_t'(addr);
    t_data[n_entries] = mem_pkg::data_t'(data);
    t_exp[n_entries]  = exp;
    n_entries++;
  endtask

  task automatic build_table();
    n_entries = 0;
    // bank 0 fills first, then bank 1 rows 0 to 3
    for (int i = 0; i < 20; i++) begin
      add_entry(0, OP_WRITE, 0, int'($urandom() & 32'hffff), i);
    end
    for (int i = 0; i < 20; i++) begin
      add_entry(1, OP_READ, i, 0, -1);
    end
    add_entry(1, OP_IDLE, 0, 0, -1);
    add_entry(1, OP_IDLE, 0, 0, -1);
    // returned rows come back in tail order
    add_entry(2, OP_DEQ, 'h05, 0, -1);
    add_entry(2, OP_WRITE, 0, 'h5a05, 'h05);
    add_entry(2, OP_WRITE, 0, 'h5a14, 'h14);
    add_entry(2, OP_DEQ, 'h09, 0, -1);
    add_entry(2, OP_DEQ, 'h02, 0, -1);
    add_entry(2, OP_WRITE, 0, 'h5a09, 'h09);
    add_entry(2, OP_WRITE, 0, 'h5a02, 'h02);
    add_entry(2, OP_WRITE, 0, 'h5a15, 'h15);
    add_entry(2, OP_READ, 'h05, 0, -1);
    add_entry(2, OP_READ, 'h09, 0, -1);
    add_entry(2, OP_READ, 'h02, 0, -1);
    add_entry(2, OP_READ, 'h14, 0, -1);
    add_entry(2, OP_IDLE, 0, 0, -1);
    add_entry(2, OP_IDLE, 0, 0, -1);
    // total drops through 40, then dequeues lift it again
    add_entry(3, OP_THR, 0, 40, -1);
    for (int i = 0; i < 4; i++) begin
      add_entry(3, OP_WRITE, 0, int'($urandom() & 32'hffff), 'h16 + i);
    end
    add_entry(3, OP_IDLE, 0, 0, -1);
    add_entry(3, OP_IDLE, 0, 0, -1);
    add_entry(3, OP_DEQ, 'h16, 0, -1);
    add_entry(3, OP_DEQ, 'h17, 0, -1);
    add_entry(3, OP_DEQ, 'h18, 0, -1);
    add_entry(3, OP_IDLE, 0, 0, -1);
    add_entry(3, OP_IDLE, 0, 0, -1);
    add_entry(3, OP_IDLE, 0, 0, -1);
  endtask

  initial begin
    int             sweep_cycles;
    int             total;
    int             bank_sel;
    int             cur_test;
    logic           exp_bp_next;
    mem_pkg::addr_t exp_addr;
    void'($urandom(32'h9be9));
    test_name[0] = "write allocation order";
    test_name[1] = "read back";
    test_name[2] = "dequeue reuse";
    test_name[3] = "back-pressure threshold";
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst     = 1'b1;
    vwrite  = 1'b0;
    vdin    = '0;
    vread   = 1'b0;
    vrdaddr = '0;
    vdeq    = 1'b0;
    vdqaddr = '0;
    bp_thr  = 8'd60;
    build_table();
    timeout_limit = n_entries + 64;

    repeat (10) begin
      @(negedge clk);
      if (ready !== 1'b0) report_mismatch("ready", 16'd0, 16'(ready));
      if (vwrite_bp !== 1'b1) report_mismatch("vwrite_bp", 16'd1, 16'(vwrite_bp));
    end
    rst = 1'b0;
    sweep_cycles = 0;
    do begin
      @(negedge clk);
      sweep_cycles++;
      if (vwrite_bp !== 1'b1) report_mismatch("vwrite_bp", 16'd1, 16'(vwrite_bp));
    end while (ready !== 1'b1);
    if (sweep_cycles != `MEM_NUM_ROWS) begin
      report_mismatch("ready low cycles", 16'(`MEM_NUM_ROWS), 16'(sweep_cycles));
    end
    close_test("reset and sweep");

    // every list holds rows 0 to 15 after the sweep
    for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
      for (int r = 0; r < `MEM_NUM_ROWS; r++) begin
        free_q[b].push_back(mem_pkg::row_t'(r));
      end
    end
    m_vld[0] = 1'b0;
    m_vld[1] = 1'b0;
    m_bp     = 1'b1;
    cur_test = t_test[0];

    for (int i = 0; i < n_entries; i++) begin
      // registered outputs from the previous edge
      if (ready !== 1'b1) report_mismatch("ready", 16'd1, 16'(ready));
      if (vwrite_bp !== m_bp) report_mismatch("vwrite_bp", 16'(m_bp), 16'(vwrite_bp));
      if (vread_vld !== m_vld[1]) report_mismatch("vread_vld", 16'(m_vld[1]), 16'(vread_vld));
      if (m_vld[1] && vdout !== m_data[1]) report_mismatch("vdout", m_data[1], vdout);
      if (t_test[i] != cur_test) begin
        close_test(test_name[cur_test]);
        cur_test = t_test[i];
      end

      vwrite  = (t_op[i] == OP_WRITE);
      vread   = (t_op[i] == OP_READ);
      vdeq    = (t_op[i] == OP_DEQ);
      vdin    = t_data[i];
      vrdaddr = t_addr[i];
      vdqaddr = t_addr[i];
      if (t_op[i] == OP_THR) bp_thr = mem_pkg::thr_t'(t_data[i]);
      #1;

      // back-pressure sees the counts before this edge
      total = 0;
      for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
        total += free_q[b].size();
      end
      exp_bp_next = (total <= int'(bp_thr));
      m_vld[1]  = m_vld[0];
      m_data[1] = m_data[0];
      m_vld[0]  = vread;
      m_data[0] = shadow[t_addr[i]];

      if (t_op[i] == OP_WRITE) begin
        bank_sel = -1;
        for (int b = 0; b < `MEM_NUM_BANKS && bank_sel < 0; b++) begin
          if (free_q[b].size() > 0) bank_sel = b;
        end
        if (bank_sel < 0) begin
          $display("write at %0t ns found no free row in the model", $time);
          errors++;
          test_errors++;
        end else begin
          exp_addr = {mem_pkg::bank_t'(bank_sel), free_q[bank_sel][0]};
          if (vwraddr !== exp_addr) report_mismatch("vwraddr", 16'(exp_addr), 16'(vwraddr));
          if (t_exp[i] >= 0 && vwraddr !== mem_pkg::addr_t'(t_exp[i])) begin
            report_mismatch("vwraddr", 16'(t_exp[i]), 16'(vwraddr));
          end
          shadow[exp_addr] = vdin;
          void'(free_q[bank_sel].pop_front());
        end
      end
      if (t_op[i] == OP_DEQ) begin
        free_q[t_addr[i][`MEM_ROW_BITS +: `MEM_BANK_BITS]].push_back(
          t_addr[i][`MEM_ROW_BITS-1:0]);
      end
      m_bp = exp_bp_next;
      @(negedge clk);
    end

    vwrite = 1'b0;
    vread  = 1'b0;
    vdeq   = 1'b0;
    if (vwrite_bp !== m_bp) report_mismatch("vwrite_bp", 16'(m_bp), 16'(vwrite_bp));
    if (vread_vld !== m_vld[1]) report_mismatch("vread_vld", 16'(m_vld[1]), 16'(vread_vld));
    close_test(test_name[cur_test]);
    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
